//--- mover_pkg.sv
////////////////////////////////////////
// Data mover shared definitions
// Widths, register map and sequencer states
////////////////////////////////////////

package mover_pkg;

    // Number of channel slots the register bank provides
    localparam int max_channels = 4;

    // Channel number and active channel count (0 to max_channels)
    typedef logic [1:0] channel_index_t;
    typedef logic [2:0] channel_count_t;

    // Payload moved from the source to the output stream
    typedef logic [31:0] data_word_t;

    // Source and target addresses share one width
    typedef logic [15:0] stream_address_t;
    typedef logic [15:0] user_tag_t;

    // Host register port
    typedef logic [3:0] reg_address_t;
    typedef logic [31:0] reg_word_t;

    // Register map, one word per entry
    // Address registers hold the source in bits 15:0 and the target in bits 31:16
    localparam reg_address_t reg_channel_count = 4'd0;
    localparam reg_address_t reg_address_base = 4'd1;
    localparam reg_address_t reg_user_base = 4'd5;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        idle = 3'd0,
        read_source = 3'd1,
        wait_response = 3'd2,
        send_buffered = 3'd3,
        wait_ready = 3'd4
    } sequencer_state_t;

endpackage

//--- mover_config_regs.sv
////////////////////////////////////////
// Mover configuration register bank
// Host write/read port and channel lookup
////////////////////////////////////////

module mover_config_regs import mover_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            cfg_write,
    input  reg_address_t    cfg_address,
    input  reg_word_t       cfg_write_data,
    input  channel_index_t  channel,
    output reg_word_t       cfg_read_data,
    output channel_count_t  channel_count,
    output stream_address_t source_address,
    output stream_address_t target_address,
    output user_tag_t       user_tag
);

    channel_count_t count_reg;
    reg_word_t address_regs [max_channels];
    user_tag_t user_regs [max_channels];

    logic is_address_reg;
    logic is_user_reg;
    channel_index_t address_slot;
    channel_index_t user_slot;
    channel_count_t count_in;
    reg_word_t read_mux;

    // Decode which register group the host is pointing at
    assign is_address_reg = (cfg_address >= reg_address_base) &&
                            (cfg_address < reg_address_base + max_channels);
    assign is_user_reg = (cfg_address >= reg_user_base) &&
                         (cfg_address < reg_user_base + max_channels);
    assign address_slot = channel_index_t'(cfg_address - reg_address_base);
    assign user_slot = channel_index_t'(cfg_address - reg_user_base);

    // A count above the number of slots is clamped to the slot count
    assign count_in = (cfg_write_data > reg_word_t'(max_channels)) ?
                      channel_count_t'(max_channels) : channel_count_t'(cfg_write_data);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_reg <= '0;
            for (int i = 0; i < max_channels; i++) begin
                address_regs[i] <= '0;
                user_regs[i] <= '0;
            end
        end else if (cfg_write) begin
            // Writes outside the map fall through every branch and are dropped
            if (cfg_address == reg_channel_count) begin
                count_reg <= count_in;
            end else if (is_address_reg) begin
                address_regs[address_slot] <= cfg_write_data;
            end else if (is_user_reg) begin
                user_regs[user_slot] <= cfg_write_data[15:0];
            end
        end
    end

    // Read-back mux, unmapped addresses give zero
    always_comb begin
        read_mux = '0;
        if (cfg_address == reg_channel_count) begin
            read_mux = reg_word_t'(count_reg);
        end else if (is_address_reg) begin
            read_mux = address_regs[address_slot];
        end else if (is_user_reg) begin
            read_mux = reg_word_t'(user_regs[user_slot]);
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clock) begin
        if (!reset) begin
            cfg_read_data <= '0;
        end else begin
            cfg_read_data <= read_mux;
        end
    end

    // Fields of the channel the sequencer is working on
    assign channel_count = count_reg;
    assign source_address = address_regs[channel][15:0];
    assign target_address = address_regs[channel][31:16];
    assign user_tag = user_regs[channel];

endmodule

//--- mover_sequencer.sv
////////////////////////////////////////
// Mover sequencer
// Walks the active channels for runs and replays
////////////////////////////////////////

module mover_sequencer import mover_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            start,
    input  logic            replay,
    input  logic            out_ready,
    input  logic            response_valid,
    input  channel_count_t  channel_count,
    input  stream_address_t source_address,
    output channel_index_t  channel,
    output logic            request_valid,
    output stream_address_t request_address,
    output logic            emit_live,
    output logic            emit_replay,
    output logic            done
);

    sequencer_state_t state;
    sequencer_state_t next_state;

    logic last_channel;
    logic advance;
    logic have_channels;

    // The counter is compared in the wider count width so a count of 4 fits
    assign last_channel = ({1'b0, channel} == channel_count - channel_count_t'(1));
    assign have_channels = (channel_count != '0);

    // A live word is emitted in the very cycle its response arrives
    assign emit_live = (state == wait_response) && response_valid;

    // Each cycle spent in send_buffered puts out one buffered word
    assign emit_replay = (state == send_buffered);

    // Every emitted word moves the channel pointer on
    assign advance = emit_live || emit_replay;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                // Start wins over replay, and nothing runs without channels
                if (have_channels && start) begin
                    next_state = read_source;
                end else if (have_channels && replay) begin
                    next_state = send_buffered;
                end
            end
            read_source: begin
                next_state = wait_response;
            end
            wait_response: begin
                if (response_valid) begin
                    next_state = last_channel ? idle : read_source;
                end
            end
            send_buffered: begin
                next_state = last_channel ? idle : wait_ready;
            end
            wait_ready: begin
                // Consumer must show ready before the next replayed word
                if (out_ready) begin
                    next_state = send_buffered;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Request goes out the cycle after read_source is entered
    always_ff @(posedge clock) begin
        if (!reset) begin
            request_valid <= 1'b0;
            request_address <= '0;
        end else begin
            request_valid <= (state == read_source);
            if (state == read_source) begin
                request_address <= source_address;
            end
        end
    end

    // Channel pointer wraps after the last active channel, done marks that word
    always_ff @(posedge clock) begin
        if (!reset) begin
            channel <= '0;
            done <= 1'b0;
        end else begin
            done <= advance && last_channel;
            if (advance) begin
                if (last_channel) begin
                    channel <= '0;
                end else begin
                    channel <= channel + channel_index_t'(1);
                end
            end
        end
    end

endmodule

//--- mover_output_stage.sv
////////////////////////////////////////
// Mover output stage
// Replay buffer and registered output stream
////////////////////////////////////////

module mover_output_stage import mover_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            emit_live,
    input  logic            emit_replay,
    input  channel_index_t  channel,
    input  data_word_t      response_data,
    input  stream_address_t target_address,
    input  user_tag_t       user_tag,
    output logic            out_valid,
    output data_word_t      out_data,
    output stream_address_t out_dest,
    output user_tag_t       out_user
);

    // One word per channel slot, filled by live transfers
    data_word_t buffer [max_channels];

    // Live words also land in the buffer so a replay can send them again
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < max_channels; i++) begin
                buffer[i] <= '0;
            end
        end else if (emit_live) begin
            buffer[channel] <= response_data;
        end
    end

    // Output beat is a single-cycle pulse, tags follow the channel lookup
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            out_data <= '0;
            out_dest <= '0;
            out_user <= '0;
        end else begin
            out_valid <= emit_live || emit_replay;
            if (emit_live || emit_replay) begin
                out_data <= emit_live ? response_data : buffer[channel];
                out_dest <= target_address;
                out_user <= user_tag;
            end
        end
    end

endmodule

//--- mover_top.sv
////////////////////////////////////////
// Register-programmed data mover
////////////////////////////////////////

module mover_top import mover_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            cfg_write,
    input  reg_address_t    cfg_address,
    input  reg_word_t       cfg_write_data,
    output reg_word_t       cfg_read_data,
    input  logic            start,
    input  logic            replay,
    output logic            request_valid,
    output stream_address_t request_address,
    input  logic            response_valid,
    input  data_word_t      response_data,
    output logic            out_valid,
    output data_word_t      out_data,
    output stream_address_t out_dest,
    output user_tag_t       out_user,
    input  logic            out_ready,
    output logic            done
);

    channel_index_t channel;
    channel_count_t channel_count;
    stream_address_t source_address;
    stream_address_t target_address;
    user_tag_t user_tag;
    logic emit_live;
    logic emit_replay;

    mover_config_regs config_regs (
        .clock          (clock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_address    (cfg_address),
        .cfg_write_data (cfg_write_data),
        .channel        (channel),
        .cfg_read_data  (cfg_read_data),
        .channel_count  (channel_count),
        .source_address (source_address),
        .target_address (target_address),
        .user_tag       (user_tag)
    );

    // Sequencer drives the channel index used by both neighbors
    mover_sequencer sequencer (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .replay          (replay),
        .out_ready       (out_ready),
        .response_valid  (response_valid),
        .channel_count   (channel_count),
        .source_address  (source_address),
        .channel         (channel),
        .request_valid   (request_valid),
        .request_address (request_address),
        .emit_live       (emit_live),
        .emit_replay     (emit_replay),
        .done            (done)
    );

    mover_output_stage output_stage (
        .clock          (clock),
        .reset          (reset),
        .emit_live      (emit_live),
        .emit_replay    (emit_replay),
        .channel        (channel),
        .response_data  (response_data),
        .target_address (target_address),
        .user_tag       (user_tag),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_dest       (out_dest),
        .out_user       (out_user)
    );

endmodule

//--- tb_mover.sv
////////////////////////////////////////
// Data mover testbench
// Source model, reference beats, stream checks
////////////////////////////////////////

module tb_mover import mover_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 2000;

    logic clock;
    logic reset;
    logic cfg_write;
    reg_address_t cfg_address;
    reg_word_t cfg_write_data;
    reg_word_t cfg_read_data;
    logic start;
    logic replay;
    logic request_valid;
    stream_address_t request_address;
    logic response_valid;
    data_word_t response_data;
    logic out_valid;
    data_word_t out_data;
    stream_address_t out_dest;
    user_tag_t out_user;
    logic out_ready;
    logic done;

    // Expected beats are {done, data, dest, user}
    logic [64:0] beat_q[$];
    stream_address_t req_q[$];
    stream_address_t src_tab [max_channels];
    stream_address_t dst_tab [max_channels];
    user_tag_t user_tab [max_channels];
    logic [31:0] rng = 32'hd154_0396;
    logic [64:0] expected_value;
    stream_address_t pending_address;
    string test_name = "startup";
    int error_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    logic live_mode = 1'b1;
    logic resp_prev = 1'b0;
    logic ready_d1 = 1'b0;
    logic ready_d2 = 1'b0;
    logic replay_d1 = 1'b0;
    logic replay_d2 = 1'b0;

    mover_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // The modeled memory returns the xorshift of the source address
    function automatic data_word_t ref_word(input stream_address_t address);
        return xorshift32({16'h0000, address});
    endfunction

    function automatic logic [64:0] expected_beat(input int ch, input logic last);
        return {last, ref_word(src_tab[ch]), dst_tab[ch], user_tab[ch]};
    endfunction

    task automatic report_mismatch(input string what, input logic [64:0] expected,
                                   input logic [64:0] actual);
        $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string text);
        $display("%s: %s", test_name, text);
        error_count++;
    endtask

    task automatic write_register(input reg_address_t address, input reg_word_t data);
        @(posedge clock);
        cfg_write <= 1'b1;
        cfg_address <= address;
        cfg_write_data <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    // Read data is registered, so it is sampled one cycle after the address
    task automatic check_register(input reg_address_t address, input reg_word_t expected);
        @(posedge clock);
        cfg_address <= address;
        @(posedge clock);
        @(negedge clock);
        if (cfg_read_data != expected) begin
            report_mismatch($sformatf("register %0d", address), expected, cfg_read_data);
        end
    endtask

    task automatic pulse_control(input logic start_level, input logic replay_level);
        @(posedge clock);
        start <= start_level;
        replay <= replay_level;
        @(posedge clock);
        start <= 1'b0;
        replay <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (beat_q.size() != 0 || req_q.size() != 0) begin
            report_failure($sformatf("%0d beats and %0d requests never arrived",
                                     beat_q.size(), req_q.size()));
            beat_q.delete();
            req_q.delete();
        end
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("Test %s: passed", test_name);
        end else begin
            $display("Test %s: failed with %0d errors", test_name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // Runs the first count channels live and waits for done
    task automatic run_live(input int count);
        live_mode = 1'b1;
        write_register(reg_channel_count, reg_word_t'(count));
        for (int ch = 0; ch < count; ch++) begin
            req_q.push_back(src_tab[ch]);
            beat_q.push_back(expected_beat(ch, ch == count - 1));
        end
        pulse_control(1'b1, 1'b0);
        do @(negedge clock); while (!done);
        repeat (4) @(posedge clock);
    endtask

    // Source model answers each request after 1 to 4 cycles
    initial begin
        forever begin
            @(negedge clock);
            if (request_valid) begin
                rng = xorshift32(rng);
                pending_address = request_address;
                repeat (int'(rng[1:0]) + 1) @(posedge clock);
                response_valid <= 1'b1;
                response_data <= ref_word(pending_address);
                @(posedge clock);
                response_valid <= 1'b0;
            end
        end
    end

    // Monitor compares requests and beats against the expected queues
    always @(negedge clock) begin
        if (request_valid) begin
            if (req_q.size() == 0) begin
                report_failure("request issued when none was expected");
            end else if (request_address != req_q[0]) begin
                report_mismatch("request address", req_q[0], request_address);
                void'(req_q.pop_front());
            end else begin
                void'(req_q.pop_front());
            end
        end
        if (out_valid) begin
            if (beat_q.size() == 0) begin
                report_failure("output beat when none was expected");
            end else begin
                expected_value = beat_q.pop_front();
                if ({done, out_data, out_dest, out_user} != expected_value) begin
                    report_mismatch("beat", expected_value, {done, out_data, out_dest, out_user});
                end
            end
            // Live beats trail their response by one cycle and replay beats need ready
            if (live_mode && !resp_prev) begin
                report_failure("live beat did not follow its response by one cycle");
            end
            if (!live_mode && !ready_d2 && !replay_d2) begin
                report_failure("replay beat sent while out_ready was low");
            end
        end else if (done) begin
            report_failure("done pulsed without an output beat");
        end
        resp_prev = response_valid;
        ready_d2 = ready_d1;
        ready_d1 = out_ready;
        replay_d2 = replay_d1;
        replay_d1 = replay;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count == timeout_cycles);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset = 1'b0;
        cfg_write = 1'b0;
        cfg_address = '0;
        cfg_write_data = '0;
        start = 1'b0;
        replay = 1'b0;
        response_valid = 1'b0;
        response_data = '0;
        out_ready = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;

        begin_test("reset state");
        repeat (3) @(negedge clock);
        if ({out_valid, request_valid, done} !== 3'b000) begin
            report_mismatch("outputs {out_valid, request_valid, done}", '0,
                            {out_valid, request_valid, done});
        end
        for (int a = 0; a < 9; a++) begin
            check_register(reg_address_t'(a), '0);
        end
        end_test();

        begin_test("register read-back");
        write_register(reg_channel_count, 32'd7);
        for (int ch = 0; ch < max_channels; ch++) begin
            rng = xorshift32(rng);
            src_tab[ch] = rng[15:0];
            dst_tab[ch] = rng[31:16];
            write_register(reg_address_base + reg_address_t'(ch), rng);
            rng = xorshift32(rng);
            user_tab[ch] = rng[15:0];
            write_register(reg_user_base + reg_address_t'(ch), rng);
        end
        // An unmapped write must leave every mapped register as it was written
        write_register(4'd9, 32'hffff_ffff);
        check_register(reg_channel_count, 32'd4);
        for (int ch = 0; ch < max_channels; ch++) begin
            check_register(reg_address_base + reg_address_t'(ch), {dst_tab[ch], src_tab[ch]});
            check_register(reg_user_base + reg_address_t'(ch), {16'h0000, user_tab[ch]});
        end
        // Unmapped register reads as zero
        check_register(4'd9, '0);
        end_test();

        begin_test("single channel");
        run_live(1);
        end_test();

        begin_test("four channels");
        run_live(4);
        end_test();

        // Buffer still holds the words of the four-channel run
        begin_test("replay");
        live_mode = 1'b0;
        for (int ch = 0; ch < max_channels; ch++) begin
            beat_q.push_back(expected_beat(ch, ch == max_channels - 1));
        end
        pulse_control(1'b0, 1'b1);
        do begin
            @(posedge clock);
            rng = xorshift32(rng);
            out_ready <= (rng[2:0] == 3'd0);
            @(negedge clock);
        end while (!done);
        @(posedge clock);
        out_ready <= 1'b0;
        repeat (4) @(posedge clock);
        end_test();

        begin_test("zero channels");
        write_register(reg_channel_count, '0);
        pulse_control(1'b1, 1'b0);
        repeat (50) @(posedge clock);
        pulse_control(1'b0, 1'b1);
        repeat (50) @(posedge clock);
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
mover_pkg.sv
mover_config_regs.sv
mover_sequencer.sv
mover_output_stage.sv
mover_top.sv
tb_mover.sv

//--- run.sh
#!/bin/sh
# Build and run the data mover testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f files.f --top-module tb_mover -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mover)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
